// ==== hw/lease_cache_pkg.sv ====
package lease_cache_pkg;

	// address split
	// ----------------------------------------
	localparam int BW_WORD_ADDR = 16;                       // core word address
	localparam int BW_BLOCK     = 2;                        // word offset within a block
	localparam int BW_TAG       = BW_WORD_ADDR - BW_BLOCK;  // [tag|word], fully associative
	localparam int BLOCK_WORDS  = 1 << BW_BLOCK;            // four words per block

	// host command word
	// ----------------------------------------
	// opcode sits in comm_i[31:30], bit 29 flags a fresh command
	localparam logic [1:0] CMD_READ_HITS   = 2'b00;  // saturating hit count
	localparam logic [1:0] CMD_READ_MISSES = 2'b01;  // saturating miss count
	localparam logic [1:0] CMD_READ_WB     = 2'b10;  // dirty evictions
	localparam logic [1:0] CMD_POP_SAMPLE  = 2'b11;  // oldest pc/tag pair
	localparam int         CMD_VALID_BIT   = 29;

	// replacement
	// ----------------------------------------
	localparam int                 BW_LEASE      = 8;   // per-line lease counter
	localparam logic [BW_LEASE-1:0] LEASE_EXPIRED = '0; // line is free to evict

endpackage

// ==== hw/tag_memory_fa.sv ====
module tag_memory_fa #(
	parameter int CACHE_BLOCK_CAPACITY = 4
)(
	input  logic                                      clock_i,
	input  logic                                      rst_n_i,
	input  logic                                      wren_i,    // install tag_wr_i at add_i
	input  logic [lease_cache_pkg::BW_TAG-1:0]        tag_i,     // lookup key
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0]   add_i,     // write / read-back line
	input  logic [lease_cache_pkg::BW_TAG-1:0]        tag_wr_i,  // tag to install
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0]   add_o,     // matching line
	output logic [lease_cache_pkg::BW_TAG-1:0]        tag_o,     // stored tag at add_i
	output logic                                      hit_o
);
	import lease_cache_pkg::*;

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);

	logic [BW_TAG-1:0]               tags_q [CACHE_BLOCK_CAPACITY];  // tag array
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_q;                        // per-line valid

	// storage
	// ----------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;                 // all lines empty
		end else if (wren_i) begin
			valid_q[add_i] <= 1'b1;        // line now resident
		end
	end

	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tags_q[add_i] <= tag_wr_i;
		end
	end

	// parallel match
	// ----------------------------------------
	always_comb begin
		hit_o = 1'b0;
		add_o = '0;
		// walk downward so the lowest matching line wins
		for (int i = CACHE_BLOCK_CAPACITY - 1; i >= 0; i--) begin
			if (valid_q[i] && (tags_q[i] == tag_i)) begin
				hit_o = 1'b1;
				add_o = BW_LINE'(i);
			end
		end
	end

	assign tag_o = tags_q[add_i];  // victim tag for writeback address

endmodule

// ==== hw/cache_data_mem.sv ====
module cache_data_mem #(
	parameter int CACHE_BLOCK_CAPACITY = 4
)(
	input  logic                                                          clock_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)+lease_cache_pkg::BW_BLOCK-1:0] add_i, // [line|word]
	input  logic                                                          wren_i,
	input  logic [31:0]                                                   data_i,
	output logic [31:0]                                                   data_o  // one cycle late
);
	import lease_cache_pkg::*;

	localparam int DEPTH = CACHE_BLOCK_CAPACITY * BLOCK_WORDS;  // total words held

	logic [31:0] mem_q [DEPTH];

	// read-first, so a write returns the old word
	always_ff @(posedge clock_i) begin
		data_o <= mem_q[add_i];
		if (wren_i) begin
			mem_q[add_i] <= data_i;
		end
	end

endmodule

// ==== hw/lease_cache_fa_controller.sv ====
module lease_cache_fa_controller #(
	parameter int                                   CACHE_BLOCK_CAPACITY = 4,
	parameter logic [lease_cache_pkg::BW_LEASE-1:0] LEASE_DEFAULT        = 8'd3,
	parameter bit                                   INIT_DONE            = 1'b0
)(
	input  logic                                          clock_i,
	input  logic                                          rst_n_i,
	input  logic                                          enable_i,    // low holds off new requests
	input  logic                                          core_req_i,
	input  logic                                          core_rw_i,   // 1 write, 0 read
	input  logic [lease_cache_pkg::BW_TAG-1:0]            core_tag_i,
	input  logic [lease_cache_pkg::BW_BLOCK-1:0]          core_word_i,
	input  logic [31:0]                                   core_data_i,
	output logic                                          core_done_o,
	output logic [31:0]                                   core_data_o,
	input  logic                                          cam_hit_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0]       cam_addr_i,  // matching line
	input  logic [lease_cache_pkg::BW_TAG-1:0]            cam_tag_i,   // tag at cam_addr_o
	output logic                                          cam_wren_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0]       cam_addr_o,
	input  logic [31:0]                                   cache_mem_data_i,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)+lease_cache_pkg::BW_BLOCK-1:0] cache_mem_add_o,
	output logic                                          cache_mem_rw_o,
	output logic [31:0]                                   cache_mem_data_o,
	input  logic                                          mem_ack_i,
	input  logic [31:0]                                   mem_data_i,
	output logic                                          mem_req_o,
	output logic                                          mem_rw_o,
	output logic [lease_cache_pkg::BW_WORD_ADDR-1:0]      mem_add_o,
	output logic [31:0]                                   mem_data_o,
	output logic                                          ref_valid_o,
	output logic                                          flag_hit_o,
	output logic                                          flag_miss_o,
	output logic                                          flag_writeback_o
);
	import lease_cache_pkg::*;

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);

	typedef enum logic [2:0] {
		ST_IDLE, ST_LOOKUP, ST_HIT, ST_VICTIM, ST_WB, ST_FILL, ST_DONE, ST_RELEASE
	} state_t;

	state_t                          state_q;
	logic [BW_LEASE-1:0]             lease_q [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_q, dirty_q;
	logic [BW_LINE-1:0]              line_q, victim_q, victim_sel, init_cnt_q;
	logic [BW_BLOCK-1:0]             word_cnt_q;   // word within the burst
	logic                            init_busy_q;  // post-reset sweep running
	logic                            missed_q;     // second lookup after a fill
	logic                            rd_ready_q;   // data memory word settled
	logic                            accept, ack_seen, fill_last, raise;

	assign accept    = (state_q == ST_IDLE) && core_req_i && enable_i && !init_busy_q;
	assign ack_seen  = mem_req_o && mem_ack_i;
	assign fill_last = (state_q == ST_FILL) && ack_seen && (word_cnt_q == '1);
	assign raise     = !mem_req_o && !mem_ack_i &&
	                   ((state_q == ST_FILL) || ((state_q == ST_WB) && rd_ready_q));

	assign core_done_o = (state_q == ST_DONE);
	assign cam_wren_o  = fill_last;    // tag goes in with the last fill word
	assign cam_addr_o  = victim_q;

	// data memory port
	// ----------------------------------------
	always_comb begin
		case (state_q)
			ST_LOOKUP:      cache_mem_add_o = {cam_addr_i, core_word_i};  // early read
			ST_WB, ST_FILL: cache_mem_add_o = {victim_q, word_cnt_q};
			default:        cache_mem_add_o = {line_q, core_word_i};
		endcase
	end

	assign cache_mem_rw_o   = ((state_q == ST_HIT) && core_rw_i) || ((state_q == ST_FILL) && ack_seen);
	assign cache_mem_data_o = (state_q == ST_FILL) ? mem_data_i : core_data_i;

	// victim choice
	// ----------------------------------------
	always_comb begin
		logic [BW_LEASE-1:0] best;
		best       = lease_q[0];
		victim_sel = '0;
		// smallest lease, lowest index on a tie, so expired lines win first
		for (int i = 1; i < CACHE_BLOCK_CAPACITY; i++) begin
			if (lease_q[i] < best) begin
				best       = lease_q[i];
				victim_sel = BW_LINE'(i);
			end
		end
		for (int i = CACHE_BLOCK_CAPACITY - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				victim_sel = BW_LINE'(i);  // empty line beats any lease
			end
		end
	end

	// state machine
	// ----------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q          <= ST_IDLE;
			valid_q          <= '0;
			init_busy_q      <= ~INIT_DONE;
			init_cnt_q       <= '0;
			word_cnt_q       <= '0;
			rd_ready_q       <= 1'b0;
			missed_q         <= 1'b0;
			mem_req_o        <= 1'b0;
			mem_rw_o         <= 1'b0;
			ref_valid_o      <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
		end else begin
			ref_valid_o      <= accept;
			flag_hit_o       <= (state_q == ST_LOOKUP) && cam_hit_i && !missed_q;
			flag_miss_o      <= (state_q == ST_LOOKUP) && !cam_hit_i;
			flag_writeback_o <= (state_q == ST_VICTIM) && valid_q[victim_sel] && dirty_q[victim_sel];
			rd_ready_q       <= !(ack_seen || (state_q == ST_VICTIM));  // new word next cycle
			if (init_busy_q) begin
				valid_q[init_cnt_q] <= 1'b0;
				init_cnt_q          <= init_cnt_q + 1'b1;
				if (init_cnt_q == BW_LINE'(CACHE_BLOCK_CAPACITY - 1)) begin
					init_busy_q <= 1'b0;
				end
			end
			if (fill_last) begin
				valid_q[victim_q] <= 1'b1;
			end
			case (state_q)
				ST_IDLE:   if (accept) state_q <= ST_LOOKUP;
				ST_LOOKUP: state_q <= cam_hit_i ? ST_HIT : ST_VICTIM;
				ST_HIT:    state_q <= ST_DONE;    // read data settles here
				ST_VICTIM: begin
					word_cnt_q <= '0;
					state_q    <= (valid_q[victim_sel] && dirty_q[victim_sel]) ? ST_WB : ST_FILL;
				end
				ST_WB, ST_FILL: begin
					if (raise) begin
						mem_req_o <= 1'b1;
						mem_rw_o  <= (state_q == ST_WB);
					end else if (ack_seen) begin
						mem_req_o  <= 1'b0;               // four-phase drop
						word_cnt_q <= word_cnt_q + 1'b1;  // wraps to 0 for the fill
						if (word_cnt_q == '1) begin
							state_q  <= (state_q == ST_WB) ? ST_FILL : ST_LOOKUP;
							missed_q <= (state_q == ST_FILL);
						end
					end
				end
				ST_DONE:   if (!core_req_i) state_q <= ST_RELEASE;
				default: begin
					missed_q <= 1'b0;   // release
					state_q  <= ST_IDLE;
				end
			endcase
		end
	end

	// lease and dirty tracking
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (init_busy_q) begin
			lease_q[init_cnt_q] <= LEASE_EXPIRED;
			dirty_q[init_cnt_q] <= 1'b0;
		end else if (accept) begin
			for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
				if (lease_q[i] != LEASE_EXPIRED) begin
					lease_q[i] <= lease_q[i] - 1'b1;   // every reference ages all lines
				end
			end
		end else if (state_q == ST_HIT) begin
			lease_q[line_q] <= LEASE_DEFAULT;
			if (core_rw_i) begin
				dirty_q[line_q] <= 1'b1;
			end
		end else if (fill_last) begin
			dirty_q[victim_q] <= 1'b0;               // clean copy of memory
		end
	end

	always_ff @(posedge clock_i) begin
		if (state_q == ST_LOOKUP) line_q <= cam_addr_i;
		if (state_q == ST_VICTIM) victim_q <= victim_sel;
		if (state_q == ST_HIT) core_data_o <= cache_mem_data_i;
		if (raise) begin
			mem_add_o  <= (state_q == ST_WB) ? {cam_tag_i, word_cnt_q} : {core_tag_i, word_cnt_q};
			mem_data_o <= cache_mem_data_i;    // only meaningful on writeback
		end
	end

endmodule

// ==== hw/cache_performance_sampler.sv ====
module cache_performance_sampler #(
	parameter int SAMPLE_DEPTH = 4
)(
	input  logic                               clock_i,
	input  logic                               rst_n_i,
	input  logic                               ref_valid_i,  // accepted core reference
	input  logic [31:0]                        pc_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0] tag_i,
	input  logic                               hit_i,
	input  logic                               miss_i,
	input  logic                               writeback_i,
	input  logic [31:0]                        comm_i,       // host command
	output logic [31:0]                        comm_o,       // host result
	output logic                               stall_o       // sample buffer full
);
	import lease_cache_pkg::*;

	localparam int BW_PTR    = (SAMPLE_DEPTH > 1) ? $clog2(SAMPLE_DEPTH) : 1;
	localparam int BW_SAMPLE = 16 + BW_TAG;  // {pc[15:0], tag}

	logic [31:0]          hits_q, misses_q, wbs_q;
	logic [BW_SAMPLE-1:0] fifo_q [SAMPLE_DEPTH];
	logic [BW_PTR-1:0]    wr_ptr_q, rd_ptr_q;
	logic [BW_PTR:0]      count_q;
	logic                 cmd_valid, push, pop;

	assign cmd_valid = comm_i[CMD_VALID_BIT];
	assign pop       = cmd_valid && (comm_i[31:30] == CMD_POP_SAMPLE) && (count_q != '0);
	assign push      = ref_valid_i && !stall_o;
	assign stall_o   = (count_q == SAMPLE_DEPTH);

	// event counters, saturating
	// ----------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hits_q   <= '0;
			misses_q <= '0;
			wbs_q    <= '0;
		end else begin
			if (hit_i && (hits_q != '1)) hits_q <= hits_q + 1'b1;
			if (miss_i && (misses_q != '1)) misses_q <= misses_q + 1'b1;
			if (writeback_i && (wbs_q != '1)) wbs_q <= wbs_q + 1'b1;
		end
	end

	// sample buffer
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (push) fifo_q[wr_ptr_q] <= {pc_i[15:0], tag_i};
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			comm_o   <= '0;
		end else begin
			if (push) wr_ptr_q <= (wr_ptr_q == BW_PTR'(SAMPLE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (pop) rd_ptr_q <= (rd_ptr_q == BW_PTR'(SAMPLE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			count_q <= count_q + push - pop;
			if (cmd_valid) begin
				case (comm_i[31:30])
					CMD_READ_HITS:   comm_o <= hits_q;
					CMD_READ_MISSES: comm_o <= misses_q;
					CMD_READ_WB:     comm_o <= wbs_q;
					default:         comm_o <= pop ? {fifo_q[rd_ptr_q][BW_SAMPLE-1 -: 16],
					                                 {(16 - BW_TAG){1'b0}},
					                                 fifo_q[rd_ptr_q][BW_TAG-1:0]} : '0;
				endcase
			end
		end
	end

endmodule

// ==== hw/lease_cache_fa_sampler.sv ====
module lease_cache_fa_sampler #(
	parameter int                                   CACHE_BLOCK_CAPACITY = 4,
	parameter logic [lease_cache_pkg::BW_LEASE-1:0] LEASE_DEFAULT        = 8'd3,
	parameter int                                   SAMPLE_DEPTH         = 4,
	parameter bit                                   INIT_DONE            = 1'b0  // 0 runs the sweep
)(
	input  logic                                     clock_i,
	input  logic                                     rst_n_i,
	input  logic [31:0]                              comm_i,
	output logic [31:0]                              comm_o,
	input  logic                                     core_req_i,
	input  logic                                     core_rw_i,
	input  logic [lease_cache_pkg::BW_WORD_ADDR-1:0] core_add_i,
	input  logic [31:0]                              core_data_i,
	input  logic [31:0]                              pc_i,
	output logic                                     core_done_o,
	output logic [31:0]                              core_data_o,
	output logic                                     hit_o,   // held for the current request
	input  logic                                     mem_ack_i,
	input  logic [31:0]                              mem_data_i,
	output logic                                     mem_req_o,
	output logic                                     mem_rw_o,
	output logic [lease_cache_pkg::BW_WORD_ADDR-1:0] mem_add_o,
	output logic [31:0]                              mem_data_o
);
	import lease_cache_pkg::*;

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);

	logic [BW_TAG-1:0]           req_tag, cam_tag;
	logic [BW_BLOCK-1:0]         req_word;
	logic [BW_LINE-1:0]          cam_addr, cam_line;
	logic [BW_LINE+BW_BLOCK-1:0] cache_add;
	logic [31:0]                 cache_wdata, cache_rdata;
	logic                        cam_wren, cam_hit, cache_wren;
	logic                        done_raw, stall, ref_valid, flag_hit, flag_miss, flag_wb;

	assign req_tag     = core_add_i[BW_WORD_ADDR-1:BW_BLOCK];
	assign req_word    = core_add_i[BW_BLOCK-1:0];
	assign core_done_o = done_raw & ~stall;   // held back while samples wait

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) hit_o <= 1'b0;
		else if (flag_hit) hit_o <= 1'b1;
		else if (flag_miss) hit_o <= 1'b0;
	end

	tag_memory_fa #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) tag_memory_fa_inst (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .wren_i(cam_wren), .tag_i(req_tag),
		.add_i(cam_addr), .tag_wr_i(req_tag), .add_o(cam_line), .tag_o(cam_tag),
		.hit_o(cam_hit)
	);

	cache_data_mem #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) cache_data_mem_inst (
		.clock_i(clock_i), .add_i(cache_add), .wren_i(cache_wren),
		.data_i(cache_wdata), .data_o(cache_rdata)
	);

	cache_performance_sampler #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) cache_performance_sampler_inst (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .ref_valid_i(ref_valid), .pc_i(pc_i),
		.tag_i(req_tag), .hit_i(flag_hit), .miss_i(flag_miss), .writeback_i(flag_wb),
		.comm_i(comm_i), .comm_o(comm_o), .stall_o(stall)
	);

	lease_cache_fa_controller #(
		.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY),
		.LEASE_DEFAULT(LEASE_DEFAULT),
		.INIT_DONE(INIT_DONE)
	) lease_cache_fa_controller_inst (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .enable_i(~stall),
		.core_req_i(core_req_i), .core_rw_i(core_rw_i), .core_tag_i(req_tag),
		.core_word_i(req_word), .core_data_i(core_data_i), .core_done_o(done_raw),
		.core_data_o(core_data_o),
		.cam_hit_i(cam_hit), .cam_addr_i(cam_line), .cam_tag_i(cam_tag),
		.cam_wren_o(cam_wren), .cam_addr_o(cam_addr),
		.cache_mem_data_i(cache_rdata), .cache_mem_add_o(cache_add),
		.cache_mem_rw_o(cache_wren), .cache_mem_data_o(cache_wdata),
		.mem_ack_i(mem_ack_i), .mem_data_i(mem_data_i), .mem_req_o(mem_req_o),
		.mem_rw_o(mem_rw_o), .mem_add_o(mem_add_o), .mem_data_o(mem_data_o),
		.ref_valid_o(ref_valid), .flag_hit_o(flag_hit), .flag_miss_o(flag_miss),
		.flag_writeback_o(flag_wb)
	);

endmodule

// ==== verification/lease_cache_asserts.sv ====
module lease_cache_asserts (
	input logic clock_i,
	input logic rst_n_i,
	input logic core_req_i,
	input logic core_done_o,
	input logic mem_req_o,
	input logic mem_ack_i,
	input logic stall_i,
	input logic accept_i,     // controller takes a request
	input logic cam_hit_i,
	input logic done_raw_i,   // done before the stall mask
	input logic flag_hit_i,
	input logic flag_miss_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;

	// reset and core port
	// ----------------------------------------
	a_reset_quiet: assert property (@(posedge clock_i)
		$rose(rst_n_i) |-> !core_done_o && !mem_req_o && !stall_i)
		else begin fail_cnt++; $error("control outputs not low after reset"); end
	a_done_needs_req: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$rose(core_done_o) |-> core_req_i)
		else begin fail_cnt++; $error("core_done_o rose without core_req_i"); end
	a_req_held: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		core_req_i && !core_done_o |=> core_req_i)
		else begin fail_cnt++; $error("core_req_i dropped before core_done_o"); end
	a_done_held: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		core_done_o && core_req_i |=> core_done_o)
		else begin fail_cnt++; $error("core_done_o dropped while core_req_i high"); end
	// lookup and hit cycles stay low, done is seen high on the third edge
	a_hit_latency: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		accept_i && cam_hit_i |=> !done_raw_i ##1 !done_raw_i ##1 done_raw_i)
		else begin fail_cnt++; $error("hit did not finish two cycles after acceptance"); end

	// memory port
	// ----------------------------------------
	a_ack_needs_req: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$rose(mem_ack_i) |-> mem_req_o)
		else begin fail_cnt++; $error("mem_ack_i rose without mem_req_o"); end
	a_mem_req_held: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		mem_req_o && !mem_ack_i |=> mem_req_o)
		else begin fail_cnt++; $error("mem_req_o dropped before mem_ack_i"); end
	a_one_in_flight: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		mem_req_o |-> core_req_i)
		else begin fail_cnt++; $error("memory traffic with no core request"); end
	// every accepted reference counts as exactly one hit or one miss
	a_one_event_per_ref: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		accept_i |-> ##2 (flag_hit_i ^ flag_miss_i))
		else begin fail_cnt++; $error("accepted reference not counted as one hit or miss"); end

endmodule

bind lease_cache_fa_sampler lease_cache_asserts asserts_inst (
	.clock_i(clock_i), .rst_n_i(rst_n_i), .core_req_i(core_req_i), .core_done_o(core_done_o),
	.mem_req_o(mem_req_o), .mem_ack_i(mem_ack_i), .stall_i(stall),
	.accept_i(lease_cache_fa_controller_inst.accept), .cam_hit_i(cam_hit),
	.done_raw_i(done_raw), .flag_hit_i(flag_hit), .flag_miss_i(flag_miss)
);

// ==== verification/lease_cache_tb.sv ====
module lease_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import lease_cache_pkg::*;

	localparam int MAX_CYCLES = 4000;             // ~20 accesses, worst miss well under 150
	localparam logic [31:0] MEM_OFS = 32'h5a00_0000;

	logic        clock_i, rst_n_i, core_req_i, core_rw_i, mem_ack_i, core_done_o, hit_o;
	logic        mem_req_o, mem_rw_o;
	logic [15:0] core_add_i, mem_add_o;
	logic [31:0] comm_i, comm_o, core_data_i, pc_i, core_data_o;
	logic [31:0] mem_data_i, mem_data_o;
	logic [31:0] mem [2**BW_WORD_ADDR];      // backing store
	logic [31:0] shadow [2**BW_WORD_ADDR];   // expected contents
	logic [15:0] rd_q[$], wr_q[$];           // memory port traffic of one access
	int          seed = 32'h530f;
	int          err_cnt, test_err, hits, refs, wbs, cycles, wait_cnt;

	lease_cache_fa_sampler #(.CACHE_BLOCK_CAPACITY(4), .LEASE_DEFAULT(8'd3), .SAMPLE_DEPTH(4))
		lease_cache_fa_sampler_inst (.*);

	initial begin
		clock_i = 1'b0;
		forever #4 clock_i = ~clock_i;   // 8 ns
	end

	// memory responder with a random ack delay
	// ----------------------------------------
	always @(posedge clock_i) begin
		if (mem_req_o && !mem_ack_i) begin
			if (wait_cnt == 0) begin
				mem_ack_i <= 1'b1;
				if (mem_rw_o) begin
					mem[mem_add_o] <= mem_data_o;
					wr_q.push_back(mem_add_o);
					check_val("mem_data_o", mem_data_o, shadow[mem_add_o]);  // writeback data
				end else begin
					mem_data_i <= mem[mem_add_o];
					rd_q.push_back(mem_add_o);
				end
				wait_cnt <= $unsigned($random(seed)) % 4;  // delay of the next word
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else if (!mem_req_o && mem_ack_i) begin
			mem_ack_i <= 1'b0;
		end
	end

	always @(posedge clock_i) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped answering", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic int fails();
		return err_cnt + lease_cache_fa_sampler_inst.asserts_inst.fail_cnt;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report(input string name);
		$display("test %-10s %s", name, (fails() == test_err) ? "ok" : "failed");
		test_err = fails();
	endtask

	task automatic host_cmd(input logic [1:0] op, output logic [31:0] res);
		@(posedge clock_i);
		comm_i                <= {op, 30'd0};
		comm_i[CMD_VALID_BIT] <= 1'b1;   // valid bit for one cycle
		@(posedge clock_i);
		comm_i <= '0;
		@(posedge clock_i);
		res = comm_o;
	endtask

	task automatic start(input logic rw, input logic [15:0] add, input logic [31:0] pc);
		@(posedge clock_i);
		rd_q.delete();
		wr_q.delete();
		core_req_i  <= 1'b1;
		core_rw_i   <= rw;
		core_add_i  <= add;
		pc_i        <= pc;
		core_data_i <= {pc[15:0], add};
		if (rw) shadow[add] = {pc[15:0], add};
		refs++;
	endtask

	task automatic finish(input logic rw, input logic [15:0] add);
		do @(posedge clock_i); while (!core_done_o);
		if (!rw) check_val("core_data_o", core_data_o, shadow[add]);
		if (hit_o) hits++;
		wbs += wr_q.size() / BLOCK_WORDS;      // one burst per dirty victim
		core_req_i <= 1'b0;
		do @(posedge clock_i); while (core_done_o);
	endtask

	task automatic pop_check(input logic [31:0] pc, input logic [15:0] add);
		logic [31:0] res;
		host_cmd(CMD_POP_SAMPLE, res);
		check_val("sample", res, {pc[15:0], 2'b00, add[15:2]});  // {pc, tag}
	endtask

	task automatic access(input logic rw, input logic [15:0] add, input logic [31:0] pc);
		start(rw, add, pc);
		finish(rw, add);
		pop_check(pc, add);
	endtask

	task automatic check_burst(input string name, input logic [15:0] q[$], input logic [15:0] base);
		check_val({name, " count"}, q.size(), BLOCK_WORDS);
		foreach (q[i]) check_val(name, q[i], base + i);   // increasing word order
	endtask

	// tests
	// ----------------------------------------
	initial begin
		logic [31:0] res;
		for (int a = 0; a < 2**BW_WORD_ADDR; a++) begin
			mem[a]    = a + MEM_OFS;
			shadow[a] = a + MEM_OFS;
		end
		{rst_n_i, core_req_i, core_rw_i, mem_ack_i} = '0;
		{core_add_i, core_data_i, pc_i, comm_i, mem_data_i} = '0;
		repeat (3) @(posedge clock_i);
		rst_n_i <= 1'b1;
		@(posedge clock_i);
		check_val("core_done_o", core_done_o, 0);
		check_val("mem_req_o", mem_req_o, 0);
		report("reset");
		access(0, 16'h0101, 32'h100);               // cold miss on block 0x0100
		check_burst("fill addr", rd_q, 16'h0100);
		report("miss_fill");
		access(1, 16'h0102, 32'h104);
		access(0, 16'h0102, 32'h108);               // read hit on the written word
		check_val("hit_o", hit_o, 1);
		report("read_hit");
		access(1, 16'h0200, 32'h200);
		access(1, 16'h0300, 32'h204);
		access(1, 16'h0400, 32'h208);
		access(1, 16'h0500, 32'h20c);               // line 0 expired and dirty
		check_burst("wb addr", wr_q, 16'h0100);
		access(0, 16'h0102, 32'h210);               // written word back from memory
		report("eviction");
		host_cmd(CMD_READ_HITS, res);
		check_val("hit count", res, hits);
		host_cmd(CMD_READ_MISSES, res);
		check_val("miss count", res, refs - hits);
		host_cmd(CMD_READ_WB, res);
		check_val("wb count", res, wbs);
		report("counters");
		for (int i = 0; i < 3; i++) begin
			start(0, 16'h0102, 32'h700 + i);
			finish(0, 16'h0102);
		end
		start(0, 16'h0102, 32'h703);                // fills the sample buffer
		repeat (12) begin
			@(posedge clock_i);
			check_val("core_done_o", core_done_o, 0);
		end
		pop_check(32'h700, 16'h0102);               // oldest reference
		finish(0, 16'h0102);
		for (int i = 1; i < 4; i++) pop_check(32'h700 + i, 16'h0102);
		report("stall");
		$display("totals: %0d refs, %0d hits, %0d writebacks, %0d errors", refs, hits, wbs,
			fails());
		if (fails() == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hw/lease_cache_pkg.sv
hw/tag_memory_fa.sv
hw/cache_data_mem.sv
hw/lease_cache_fa_controller.sv
hw/cache_performance_sampler.sv
hw/lease_cache_fa_sampler.sv
verification/lease_cache_asserts.sv
verification/lease_cache_tb.sv

// ==== Bender.yml ====
package:
  name: lease_cache

sources:
  - hw/lease_cache_pkg.sv
  - hw/tag_memory_fa.sv
  - hw/cache_data_mem.sv
  - hw/lease_cache_fa_controller.sv
  - hw/cache_performance_sampler.sv
  - hw/lease_cache_fa_sampler.sv
  - target: test
    files:
      - verification/lease_cache_asserts.sv
      - verification/lease_cache_tb.sv
